/* Makefile */
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -j 0
TOP       = trace_monitor_tb
FILELIST  = build.f
PASS_MSG  = *** TEST PASSED ***

.PHONY: simulate clean

simulate:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST)
	@out="$$(./obj_dir/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -qF "$(PASS_MSG)"

clean:
	rm -rf obj_dir

/* build.f */
verilog/riscv_cause_pkg.sv
verilog/trace_mon_pkg.sv
verilog/retire_capture.sv
verilog/trace_fifo.sv
verilog/trace_rule_checker.sv
verilog/trace_monitor_top.sv
tb/tb_clkgen.sv
tb/trace_monitor_sva.sv
tb/trace_monitor_tb.sv

/* tb/tb_clkgen.sv */
// Testbench clock and reset
// Free running 20 ns clock with an active low reset held for the first cycles

`timescale 1ns/1ps

module tb_clkgen #(
  parameter int unsigned RST_CYCLES = 4
) (
  output logic clk_o,
  output logic rst_no
);

  // Half period of 10 ns gives the 20 ns clock
  initial begin
    clk_o = 1'b0;
    forever begin
      #10 clk_o = ~clk_o;
    end
  end

  // Reset goes away on a rising edge, after the DUT has seen it for a few cycles
  initial begin
    rst_no <= 1'b0;
    repeat (RST_CYCLES) @(posedge clk_o);
    rst_no <= 1'b1;
  end

endmodule : tb_clkgen

/* tb/trace_monitor_sva.sv */
// Monitor assertions
// Pop handshake between FIFO and checker, monotonic checked count and
// sticky overflow, bound into the monitor top level

`timescale 1ns/1ps

module trace_monitor_sva
  import trace_mon_pkg::*;
(
  input logic   clk_i,
  input logic   rst_ni,
  input logic   clear_i,
  input logic   pop_i,
  input logic   avail_i,
  input count_t count_i,
  input logic   sticky_i
);

  // A record is only taken while one sits at the head
  pop_needs_avail: assert property (
    @(posedge clk_i) disable iff (!rst_ni) pop_i |-> avail_i
  ) else $error("Pop seen while no record was available");

  // Counts only move up, clear is the one way back to zero
  count_no_decrease: assert property (
    @(posedge clk_i) disable iff (!rst_ni) !clear_i |=> (count_i >= $past(count_i))
  ) else $error("Checked count went down without a clear");

  // Once a record is lost the flag stays until software clears it
  sticky_until_clear: assert property (
    @(posedge clk_i) disable iff (!rst_ni) (sticky_i && !clear_i) |=> sticky_i
  ) else $error("Overflow flag dropped without a clear");

endmodule : trace_monitor_sva

// The top level is where the FIFO pop handshake, the checked count and the overflow flag meet
bind trace_monitor_top trace_monitor_sva u_monitor_sva (
  .clk_i    (clk_i),
  .rst_ni   (rst_ni),
  .clear_i  (clear_i),
  .pop_i    (rec_pop),
  .avail_i  (rec_avail),
  .count_i  (checked_o),
  .sticky_i (overflow_o)
);

/* tb/trace_monitor_tb.sv */
// Retirement trace monitor testbench
// Replays retirement groups from the stimulus file and compares flags,
// counts and overflow with the expected line that closes each group

`timescale 1ns/1ps

module trace_monitor_tb
  import riscv_cause_pkg::*;
  import trace_mon_pkg::*;
();

  localparam int unsigned FIFO_DEPTH = 4;
  localparam int unsigned ACK_CNT_W  = 2;
  localparam int WAIT_CYCLES   = 64;
  localparam int WDOG_PER_LINE = 40;
  localparam string STIM_FILE  = "tb/trace_stim.txt";

  // One retirement line of the stimulus file
  typedef struct packed {
    logic       retire;
    logic       intr;
    dbg_cause_t dbg;
    trap_info_t trap;
    exc_cause_t mcause;
    logic       step;
    logic       dmode;
    logic       ack;
    logic       hold;
    logic [7:0] idle;
  } retire_line_t;

  // Monitor state expected once a group has drained
  typedef struct packed {
    rule_flags_t flags;
    count_t      errors;
    count_t      checked;
    logic        overflow;
  } expect_t;

  logic        clk, rst_n, clear, hold;
  logic        retire_valid, rvfi_intr, dcsr_step, debug_mode, dbg_ack;
  dbg_cause_t  rvfi_dbg;
  trap_info_t  rvfi_trap;
  exc_cause_t  mcause;
  rule_flags_t flags;
  count_t      checked, errors;
  logic        overflow;

  retire_line_t line_q[$];
  expect_t      exp_q[$];
  int           group_start_q[$];
  int           group_end_q[$];
  int           line_total;
  bit           load_done;
  int           tests_run, tests_passed, tests_failed;

  tb_clkgen u_clkgen (.clk_o(clk), .rst_no(rst_n));

  trace_monitor_top #(
    .FIFO_DEPTH (FIFO_DEPTH),
    .ACK_CNT_W  (ACK_CNT_W)
  ) UUT (
    .clk_i (clk), .rst_ni (rst_n), .clear_i (clear), .hold_i (hold),
    .retire_valid_i (retire_valid), .rvfi_intr_i (rvfi_intr), .rvfi_dbg_i (rvfi_dbg),
    .rvfi_trap_i (rvfi_trap), .mcause_i (mcause), .dcsr_step_i (dcsr_step),
    .debug_mode_i (debug_mode), .dbg_ack_i (dbg_ack),
    .flags_o (flags), .checked_o (checked), .errors_o (errors), .overflow_o (overflow)
  );

  //////////////////////////////////////////////////////////////////////
  // Stimulus file
  //////////////////////////////////////////////////////////////////////

  // R lines are retirements, an E line closes the group before it
  task automatic load_stimulus(output bit ok);
    int           fd;
    int           n;
    int           f[13];
    string        text;
    retire_line_t rl;
    expect_t      ex;
    ok = 1'b0;
    fd = $fopen(STIM_FILE, "r");
    if (fd == 0) begin
      $display("Could not open the stimulus file %s", STIM_FILE);
      return;
    end
    ok = 1'b1;
    group_start_q.push_back(0);
    while ($fgets(text, fd) > 0) begin
      if (text.getc(0) == "R") begin
        n = $sscanf(text, "R %h %h %h %h %h %h %h %h %h %h %h %h %h", f[0], f[1], f[2],
                    f[3], f[4], f[5], f[6], f[7], f[8], f[9], f[10], f[11], f[12]);
        if (n != 13) begin
          $display("Retirement line %0d of the stimulus file is malformed", line_total + 1);
          ok = 1'b0;
        end
        rl.retire = f[0][0];
        rl.intr   = f[1][0];
        rl.dbg    = dbg_cause_t'(f[2]);
        rl.trap.exception       = f[3][0];
        rl.trap.debug           = f[4][0];
        rl.trap.exception_cause = exc_cause_t'(f[5]);
        rl.trap.debug_cause     = dbg_cause_t'(f[6]);
        rl.mcause = exc_cause_t'(f[7]);
        rl.step   = f[8][0];
        rl.dmode  = f[9][0];
        rl.ack    = f[10][0];
        rl.hold   = f[11][0];
        rl.idle   = f[12][7:0];
        line_q.push_back(rl);
        line_total++;
      end else if (text.getc(0) == "E") begin
        n = $sscanf(text, "E %h %h %h %h", f[0], f[1], f[2], f[3]);
        if (n != 4) begin
          $display("Expected line %0d of the stimulus file is malformed", line_total + 1);
          ok = 1'b0;
        end
        ex.flags    = rule_flags_t'(f[0][4:0]);
        ex.errors   = count_t'(f[1]);
        ex.checked  = count_t'(f[2]);
        ex.overflow = f[3][0];
        exp_q.push_back(ex);
        group_end_q.push_back(line_q.size());
        group_start_q.push_back(line_q.size());
        line_total++;
      end
    end
    $fclose(fd);
  endtask

  //////////////////////////////////////////////////////////////////////
  // Drivers
  //////////////////////////////////////////////////////////////////////

  task automatic pulse_clear();
    @(posedge clk);
    clear <= 1'b1;
    @(posedge clk);
    clear <= 1'b0;
  endtask

  // Strobes last one cycle, levels hold until the next line
  task automatic drive_line(input retire_line_t rl);
    @(posedge clk);
    retire_valid <= rl.retire;
    rvfi_intr    <= rl.intr;
    rvfi_dbg     <= rl.dbg;
    rvfi_trap    <= rl.trap;
    mcause       <= rl.mcause;
    dcsr_step    <= rl.step;
    debug_mode   <= rl.dmode;
    dbg_ack      <= rl.ack;
    hold         <= rl.hold;
    repeat (rl.idle) begin
      @(posedge clk);
      retire_valid <= 1'b0;
      dbg_ack      <= 1'b0;
    end
  endtask

  task automatic run_group(input int g);
    expect_t ex;
    int      waited;
    string   msg;
    ex = exp_q[g];
    pulse_clear();
    for (int i = group_start_q[g]; i < group_end_q[g]; i++) begin
      drive_line(line_q[i]);
    end
    @(posedge clk);
    retire_valid <= 1'b0;
    dbg_ack      <= 1'b0;
    hold         <= 1'b0;
    // Outputs are read on the falling edge, away from the DUT's updates
    waited = 0;
    while ((checked != ex.checked) && (waited < WAIT_CYCLES)) begin
      @(negedge clk);
      waited++;
    end
    tests_run++;
    if (checked != ex.checked) begin
      $display("Test %0d timed out with %0d records checked while %0d were expected",
               g + 1, checked, ex.checked);
      tests_failed++;
      return;
    end
    // A few more cycles show up any record checked beyond the expected count
    repeat (3) @(negedge clk);
    msg = "";
    if (flags != ex.flags) begin
      msg = {msg, $sformatf(" flags %b expected %b;", flags, ex.flags)};
    end
    if (errors != ex.errors) begin
      msg = {msg, $sformatf(" errors %0d expected %0d;", errors, ex.errors)};
    end
    if (checked != ex.checked) begin
      msg = {msg, $sformatf(" checked %0d expected %0d;", checked, ex.checked)};
    end
    if (overflow != ex.overflow) begin
      msg = {msg, $sformatf(" overflow %b expected %b;", overflow, ex.overflow)};
    end
    if (msg.len() != 0) begin
      $display("Fail %0t: test %0d%s", $time, g + 1, msg);
      tests_failed++;
    end else begin
      $display("Test %0d passed with flags %b, %0d errors, %0d checked, overflow %b",
               g + 1, flags, errors, checked, overflow);
      tests_passed++;
    end
  endtask

  //////////////////////////////////////////////////////////////////////
  // Sequence and watchdog
  //////////////////////////////////////////////////////////////////////

  initial begin : main_seq
    bit loaded;
    clear        <= 1'b0;
    hold         <= 1'b0;
    retire_valid <= 1'b0;
    rvfi_intr    <= 1'b0;
    rvfi_dbg     <= DBG_CAUSE_NONE;
    rvfi_trap    <= '0;
    mcause       <= '0;
    dcsr_step    <= 1'b0;
    debug_mode   <= 1'b0;
    dbg_ack      <= 1'b0;
    tests_run    = 0;
    tests_passed = 0;
    tests_failed = 0;
    line_total   = 0;
    load_stimulus(loaded);
    load_done = 1'b1;
    if (!loaded) begin
      tests_failed++;
    end else if (exp_q.size() == 0) begin
      $display("The stimulus file holds no test");
      tests_failed++;
    end
    wait (rst_n === 1'b1);
    for (int g = 0; g < exp_q.size(); g++) begin
      run_group(g);
    end
    $display("Totals: %0d tests run, %0d passed, %0d failed",
             tests_run, tests_passed, tests_failed);
    if (tests_failed == 0) begin
      $display("*** TEST PASSED ***");
    end else begin
      $display("*** TEST FAILED ***");
    end
    $finish;
  end

  // Bound grows with the stimulus, one spare line keeps it above the reset time
  initial begin : watchdog
    wait (load_done);
    repeat ((line_total + 1) * WDOG_PER_LINE) @(posedge clk);
    $display("The watchdog expired before all tests had finished");
    $display("*** TEST FAILED ***");
    $finish;
  end

endmodule : trace_monitor_tb

/* tb/trace_stim.txt */
# R ret intr dbg exc dbgbit exc_cause dbg_cause mcause step dmode ack hold idle (hex)
# E flags errors checked overflow, flags are trap_intr dbg_align step_cause mcause_align dbg_no_ack
# Test 1: legal trap with handler entry, then an acknowledged ebreak entry
R 1 0 0 0 0 00 0 00 0 0 0 0 1
R 1 0 0 1 0 02 0 00 0 0 0 0 0
R 1 1 0 0 0 00 0 02 0 0 0 0 0
R 1 0 0 0 0 00 0 02 0 0 0 0 0
R 1 0 0 0 1 00 1 02 0 0 1 0 0
R 1 1 1 0 0 00 0 02 0 1 0 0 2
E 00 0 6 0
# Test 2: missing intr after a trap, then the same trap in debug mode
R 1 0 0 1 0 0b 0 00 0 0 0 0 0
R 1 0 0 0 0 00 0 0b 0 0 0 0 0
R 1 0 0 1 0 0b 0 0b 0 1 0 0 0
R 1 0 0 0 0 00 0 00 0 1 0 0 1
E 10 1 4 0
# Test 3: ebreak answered by a step entry, then an exception while stepping
R 1 0 0 0 1 00 1 00 0 0 1 0 0
R 1 1 4 0 0 00 0 00 0 1 0 0 0
R 1 0 0 1 1 02 1 00 1 0 0 0 1
E 0c 2 3 0
# Test 4: wrong mcause twice, the last record breaks two rules
R 1 0 0 1 0 05 0 00 0 0 0 0 0
R 1 1 0 1 0 03 0 07 0 0 0 0 0
R 1 0 0 0 0 00 0 01 0 0 0 0 1
E 12 2 3 0
# Test 5: entry without ack, ack alone, entry after it, entry with ack alongside
R 1 1 1 0 0 00 0 00 0 1 0 0 0
R 0 0 0 0 0 00 0 00 0 1 1 0 0
R 1 1 1 0 0 00 0 00 0 1 0 0 0
R 1 0 4 0 0 00 0 00 0 1 1 0 1
E 01 1 3 0
# Test 6: checker held while six records arrive
R 1 0 0 0 0 00 0 00 0 0 0 1 0
R 1 0 0 0 0 00 0 00 0 0 0 1 0
R 1 0 0 0 0 00 0 00 0 0 0 1 0
R 1 0 0 0 0 00 0 00 0 0 0 1 0
R 1 0 0 0 0 00 0 00 0 0 0 1 0
R 1 0 0 0 0 00 0 00 0 0 0 1 0
E 00 0 4 1

/* verilog/retire_capture.sv */
// Retirement capture stage
// Turns each retirement strobe into one registered trace record and
// counts debug acknowledges that are still waiting for their debug entry

`timescale 1ns/1ps

module retire_capture
  import riscv_cause_pkg::*;
  import trace_mon_pkg::*;
#(
  parameter int unsigned ACK_CNT_W = 2
) (
  input  logic       clk_i,
  input  logic       rst_ni,
  input  logic       retire_valid_i,
  input  logic       rvfi_intr_i,
  input  dbg_cause_t rvfi_dbg_i,
  input  trap_info_t rvfi_trap_i,
  input  exc_cause_t mcause_i,
  input  logic       dcsr_step_i,
  input  logic       debug_mode_i,
  input  logic       dbg_ack_i,
  output logic       rec_push_o,
  output trace_rec_t rec_o
);

  localparam logic [ACK_CNT_W-1:0] ACK_CNT_MAX = '1;

  logic [ACK_CNT_W-1:0] ack_cnt_q;
  logic                 dbg_entry;
  logic                 ack_inc;
  logic                 ack_dec;

  // A retirement that enters debug consumes one acknowledge
  assign dbg_entry = retire_valid_i && (rvfi_dbg_i != DBG_CAUSE_NONE);

  // An ack and an entry in the same cycle cancel out
  // Both ends saturate so the count never wraps
  assign ack_inc = dbg_ack_i && !dbg_entry && (ack_cnt_q != ACK_CNT_MAX);
  assign ack_dec = dbg_entry && !dbg_ack_i && (ack_cnt_q != '0);

  //////////////////////////////////////////////////////////////////////
  // Outstanding acknowledge count
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      ack_cnt_q <= '0;
    end else if (ack_inc) begin
      ack_cnt_q <= ack_cnt_q + 1'b1;
    end else if (ack_dec) begin
      ack_cnt_q <= ack_cnt_q - 1'b1;
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Record register
  //////////////////////////////////////////////////////////////////////

  // Push strobe follows the retire strobe by one cycle
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      rec_push_o <= 1'b0;
    end else begin
      rec_push_o <= retire_valid_i;
    end
  end

  // The record is only loaded on a retirement and is meaningless otherwise
  always_ff @(posedge clk_i) begin
    if (retire_valid_i) begin
      rec_o.intr      <= rvfi_intr_i;
      rec_o.dbg       <= rvfi_dbg_i;
      rec_o.trap      <= rvfi_trap_i;
      rec_o.mcause_lo <= mcause_i;
      // Stepping or debug mode suspends the trap rules
      rec_o.no_debug  <= !(dcsr_step_i || debug_mode_i);
      // An ack in the same cycle as the entry also counts as preceding it
      rec_o.ack_ok    <= (ack_cnt_q != '0) || dbg_ack_i;
    end
  end

endmodule : retire_capture

/* verilog/riscv_cause_pkg.sv */
// RISC-V cause encodings
// Exception cause and debug cause values, as the core reports them at
// retirement and in mcause and dcsr

package riscv_cause_pkg;

  //////////////////////////////////////////////////////////////////////
  // Cause widths
  //////////////////////////////////////////////////////////////////////

  // Only the low six bits of mcause are tracked by the monitor
  typedef logic [5:0] exc_cause_t;

  // Debug cause as carried in dcsr.cause and on the rvfi_dbg field
  typedef logic [2:0] dbg_cause_t;

  //////////////////////////////////////////////////////////////////////
  // Debug causes
  //////////////////////////////////////////////////////////////////////

  // No debug entry on this retirement
  localparam dbg_cause_t DBG_CAUSE_NONE   = 3'h0;

  // Entry through an ebreak instruction
  localparam dbg_cause_t DBG_CAUSE_EBREAK = 3'h1;

  // Entry after a single step, also used when an exception hits a stepped instruction
  localparam dbg_cause_t DBG_CAUSE_STEP   = 3'h4;

endpackage : riscv_cause_pkg

/* verilog/trace_fifo.sv */
// Trace record FIFO
// Circular buffer with show-ahead read, drops pushes when full and keeps a
// sticky overflow flag until cleared

`timescale 1ns/1ps

module trace_fifo
  import trace_mon_pkg::*;
#(
  parameter int unsigned FIFO_DEPTH = 4
) (
  input  logic       clk_i,
  input  logic       rst_ni,
  input  logic       clear_i,
  input  logic       push_i,
  input  trace_rec_t data_i,
  input  logic       pop_i,
  output logic       avail_o,
  output trace_rec_t head_o,
  output logic       overflow_o
);

  localparam int unsigned PTR_W = (FIFO_DEPTH > 1) ? $clog2(FIFO_DEPTH) : 1;
  localparam int unsigned CNT_W = $clog2(FIFO_DEPTH + 1);
  localparam logic [PTR_W-1:0] LAST_PTR = PTR_W'(FIFO_DEPTH - 1);
  localparam logic [CNT_W-1:0] FULL_CNT = CNT_W'(FIFO_DEPTH);

  trace_rec_t       mem_q [FIFO_DEPTH];
  logic [PTR_W-1:0] wr_ptr_q;
  logic [PTR_W-1:0] rd_ptr_q;
  logic [CNT_W-1:0] cnt_q;
  logic             full;
  logic             do_push;
  logic             do_pop;

  assign full    = (cnt_q == FULL_CNT);
  assign avail_o = (cnt_q != '0);
  assign head_o  = mem_q[rd_ptr_q];

  // A push into a full buffer is lost, even if a pop happens alongside
  assign do_push = push_i && !full;
  assign do_pop  = pop_i && avail_o;

  // Storage, written only on an accepted push
  always_ff @(posedge clk_i) begin
    if (do_push) begin
      mem_q[wr_ptr_q] <= data_i;
    end
  end

  // Pointers wrap at the depth so any depth works, not just powers of two
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      cnt_q    <= '0;
    end else begin
      if (do_push) begin
        wr_ptr_q <= (wr_ptr_q == LAST_PTR) ? '0 : wr_ptr_q + 1'b1;
      end
      if (do_pop) begin
        rd_ptr_q <= (rd_ptr_q == LAST_PTR) ? '0 : rd_ptr_q + 1'b1;
      end
      if (do_push && !do_pop) begin
        cnt_q <= cnt_q + 1'b1;
      end else if (do_pop && !do_push) begin
        cnt_q <= cnt_q - 1'b1;
      end
    end
  end

  // Sticky loss indication, clear takes priority over a new drop
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      overflow_o <= 1'b0;
    end else if (clear_i) begin
      overflow_o <= 1'b0;
    end else if (push_i && full) begin
      overflow_o <= 1'b1;
    end
  end

endmodule : trace_fifo

/* verilog/trace_mon_pkg.sv */
// Retirement trace monitor formats
// Record layout, rule flag layout and counter width used between the
// capture stage, the record FIFO and the rule checker

package trace_mon_pkg;

  import riscv_cause_pkg::*;

  //////////////////////////////////////////////////////////////////////
  // Trap information of one retirement
  //////////////////////////////////////////////////////////////////////

  // Exception and debug bits with the cause of each, 11 bits
  typedef struct packed {
    logic       exception;
    logic       debug;
    exc_cause_t exception_cause;
    dbg_cause_t debug_cause;
  } trap_info_t;

  //////////////////////////////////////////////////////////////////////
  // One record per retirement, 23 bits
  //////////////////////////////////////////////////////////////////////

  typedef struct packed {
    logic       intr;       // First instruction of a trap handler
    dbg_cause_t dbg;        // Debug entry cause, zero when no entry
    trap_info_t trap;       // Trap raised by this instruction
    exc_cause_t mcause_lo;  // mcause[5:0] as read at retirement
    logic       no_debug;   // Neither stepping nor in debug mode
    logic       ack_ok;     // A debug acknowledge was outstanding
  } trace_rec_t;

  // Sticky rule violation bits, one per consistency rule
  typedef struct packed {
    logic trap_intr;
    logic dbg_align;
    logic step_cause;
    logic mcause_align;
    logic dbg_no_ack;
  } rule_flags_t;

  // Width of the checked and error counters
  typedef logic [15:0] count_t;

endpackage : trace_mon_pkg

/* verilog/trace_monitor_top.sv */
// Retirement trace monitor
// Capture stage feeds a record FIFO that drains into the rule checker,
// hold pauses the checker so the FIFO can fill

`timescale 1ns/1ps

module trace_monitor_top
  import riscv_cause_pkg::*;
  import trace_mon_pkg::*;
#(
  parameter int unsigned FIFO_DEPTH = 4,
  parameter int unsigned ACK_CNT_W  = 2
) (
  input  logic        clk_i,
  input  logic        rst_ni,
  input  logic        clear_i,
  input  logic        hold_i,
  input  logic        retire_valid_i,
  input  logic        rvfi_intr_i,
  input  dbg_cause_t  rvfi_dbg_i,
  input  trap_info_t  rvfi_trap_i,
  input  exc_cause_t  mcause_i,
  input  logic        dcsr_step_i,
  input  logic        debug_mode_i,
  input  logic        dbg_ack_i,
  output rule_flags_t flags_o,
  output count_t      checked_o,
  output count_t      errors_o,
  output logic        overflow_o
);

  logic       rec_push;
  trace_rec_t rec_data;
  logic       rec_avail;
  trace_rec_t rec_head;
  logic       rec_pop;

  //////////////////////////////////////////////////////////////////////
  // Producer
  //////////////////////////////////////////////////////////////////////

  retire_capture #(
    .ACK_CNT_W (ACK_CNT_W)
  ) u_capture (
    .clk_i          (clk_i),
    .rst_ni         (rst_ni),
    .retire_valid_i (retire_valid_i),
    .rvfi_intr_i    (rvfi_intr_i),
    .rvfi_dbg_i     (rvfi_dbg_i),
    .rvfi_trap_i    (rvfi_trap_i),
    .mcause_i       (mcause_i),
    .dcsr_step_i    (dcsr_step_i),
    .debug_mode_i   (debug_mode_i),
    .dbg_ack_i      (dbg_ack_i),
    .rec_push_o     (rec_push),
    .rec_o          (rec_data)
  );

  // Buffer between capture and checker, the capture side never waits
  trace_fifo #(
    .FIFO_DEPTH (FIFO_DEPTH)
  ) u_fifo (
    .clk_i      (clk_i),
    .rst_ni     (rst_ni),
    .clear_i    (clear_i),
    .push_i     (rec_push),
    .data_i     (rec_data),
    .pop_i      (rec_pop),
    .avail_o    (rec_avail),
    .head_o     (rec_head),
    .overflow_o (overflow_o)
  );

  //////////////////////////////////////////////////////////////////////
  // Consumer
  //////////////////////////////////////////////////////////////////////

  trace_rule_checker u_checker (
    .clk_i     (clk_i),
    .rst_ni    (rst_ni),
    .clear_i   (clear_i),
    .hold_i    (hold_i),
    .avail_i   (rec_avail),
    .head_i    (rec_head),
    .pop_o     (rec_pop),
    .flags_o   (flags_o),
    .checked_o (checked_o),
    .errors_o  (errors_o)
  );

endmodule : trace_monitor_top

/* verilog/trace_rule_checker.sv */
// Retirement rule checker
// Pops trace records, compares each with the one before it and keeps sticky
// violation flags together with checked and error counts

`timescale 1ns/1ps

module trace_rule_checker
  import riscv_cause_pkg::*;
  import trace_mon_pkg::*;
(
  input  logic        clk_i,
  input  logic        rst_ni,
  input  logic        clear_i,
  input  logic        hold_i,
  input  logic        avail_i,
  input  trace_rec_t  head_i,
  output logic        pop_o,
  output rule_flags_t flags_o,
  output count_t      checked_o,
  output count_t      errors_o
);

  trace_rec_t  prev_q;
  logic        prev_valid_q;
  logic        prev_trap;
  rule_flags_t viol;

  // Records are taken as soon as they show up unless the checker is held
  assign pop_o = avail_i && !hold_i;

  // Any trap bit on the previous retirement counts as a trap
  assign prev_trap = prev_q.trap.exception || prev_q.trap.debug;

  //////////////////////////////////////////////////////////////////////
  // Rule evaluation
  //////////////////////////////////////////////////////////////////////

  always_comb begin
    // Outside debug, the retirement after a trap is the handler entry
    viol.trap_intr = prev_valid_q && prev_trap && prev_q.no_debug && !head_i.intr;

    // A debug trap must be followed by an entry with the same cause
    viol.dbg_align = prev_valid_q && prev_q.trap.debug &&
                     ((head_i.dbg != prev_q.trap.debug_cause) ||
                      (head_i.dbg == DBG_CAUSE_NONE));

    // Exception and debug bits together only happen while stepping
    viol.step_cause = head_i.trap.exception && head_i.trap.debug &&
                      (head_i.trap.debug_cause != DBG_CAUSE_STEP);

    // mcause is not written in debug mode, so only check outside it
    viol.mcause_align = prev_valid_q && prev_q.trap.exception && prev_q.no_debug &&
                        (head_i.mcause_lo != prev_q.trap.exception_cause);

    // This rule looks at the current record alone
    viol.dbg_no_ack = (head_i.dbg != DBG_CAUSE_NONE) && !head_i.ack_ok;
  end

  //////////////////////////////////////////////////////////////////////
  // Flags, counts and the previous record
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      flags_o      <= '0;
      checked_o    <= '0;
      errors_o     <= '0;
      prev_valid_q <= 1'b0;
    end else if (clear_i) begin
      flags_o      <= '0;
      checked_o    <= '0;
      errors_o     <= '0;
      prev_valid_q <= 1'b0;
    end else if (pop_o) begin
      flags_o      <= flags_o | viol;
      checked_o    <= checked_o + count_t'(1);
      // A record with several violations still counts as one error
      errors_o     <= errors_o + count_t'(|viol);
      prev_valid_q <= 1'b1;
    end
  end

  // Only read while prev_valid_q is set, which the reset and clear above guard
  always_ff @(posedge clk_i) begin
    if (pop_o) begin
      prev_q <= head_i;
    end
  end

endmodule : trace_rule_checker
